// ==== Makefile ====
TOP := exe_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o sim_exe
	./obj_dir/sim_exe +verilator+error+limit+1000

clean:
	rm -rf obj_dir

// ==== bench/exe_core_asserts.sv ====
`timescale 1ns/1ns

module exe_core_asserts
    import rv_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     in_valid,
    input t_uop     in_uop,
    input t_reg_idx in_rs1,
    input t_reg_idx in_rs2,
    input t_reg_idx in_rd,
    input t_optype  in_src2_type,
    input t_data    in_imm,
    input t_data    in_pc,
    input logic     ex1_valid,
    input t_uop     ex1_uop,
    input t_reg_idx ex1_rd,
    input t_data    ex1_result,
    input logic     ex1_result_valid,
    input logic     ex1_br_valid,
    input logic     ex1_br_taken,
    input t_data    ex1_br_tgt
);

    t_data       shadow [num_regs];
    t_data       src1;
    t_data       src2;
    t_data       alu_val;
    logic [4:0]  sh;
    logic        alu_hit;
    logic        br_hit;
    logic        lt_s;
    logic        taken;
    logic        exp_valid;
    logic        exp_res_v;
    logic        exp_br_v;
    logic        exp_taken;
    t_uop        exp_uop;
    t_reg_idx    exp_rd;
    t_data       exp_result;
    t_data       exp_tgt;
    logic        stall_q;
    logic [76:0] out_now;
    logic [76:0] out_prev;
    int          err_count = 0;

    assign out_now = {ex1_valid, ex1_uop, ex1_rd, ex1_result, ex1_result_valid,
                      ex1_br_valid, ex1_br_taken, ex1_br_tgt};

    // Reference model of EX0, x0 of the shadow array is never written
    always_comb begin
        alu_hit = in_uop inside {U_ADD, U_SUB, U_AND, U_OR, U_XOR,
                                 U_SLT, U_SLTU, U_SLL, U_SRL, U_SRA};
        br_hit  = in_uop inside {U_BEQ, U_BNE, U_BLT, U_BGE};
        src1    = shadow[in_rs1];
        // Branches compare two registers, the immediate is their offset
        src2    = (in_src2_type == OP_IMM && !br_hit) ? in_imm : shadow[in_rs2];
        lt_s    = (src1[31] != src2[31]) ? src1[31] : (src1 < src2);
        sh      = src2[4:0];
        case (in_uop)
            U_ADD:   alu_val = src1 + src2;
            U_SUB:   alu_val = src1 + ~src2 + 32'd1;
            U_AND:   alu_val = src1 & src2;
            U_OR:    alu_val = src1 | src2;
            U_XOR:   alu_val = src1 ^ src2;
            U_SLT:   alu_val = {31'd0, lt_s};
            U_SLTU:  alu_val = {31'd0, src1 < src2};
            U_SLL:   alu_val = src1 << sh;
            U_SRL:   alu_val = src1 >> sh;
            // Vacated high bits take the sign
            U_SRA:   alu_val = (src1 >> sh) | ({32{src1[31]}} & ~(32'hffff_ffff >> sh));
            default: alu_val = '0;
        endcase
        case (in_uop)
            U_BEQ:   taken = (src1 == src2);
            U_BNE:   taken = (src1 != src2);
            U_BLT:   taken = lt_s;
            U_BGE:   taken = !lt_s;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                shadow[i] <= '0;
            end
            exp_valid  <= 1'b0;
            exp_res_v  <= 1'b0;
            exp_br_v   <= 1'b0;
            exp_taken  <= 1'b0;
            exp_uop    <= U_INVALID;
            exp_rd     <= '0;
            exp_result <= '0;
            exp_tgt    <= '0;
            stall_q    <= 1'b0;
            out_prev   <= '0;
        end else begin
            stall_q  <= stall;
            out_prev <= out_now;
            if (!stall) begin
                exp_valid  <= in_valid;
                exp_res_v  <= in_valid && alu_hit;
                exp_br_v   <= in_valid && br_hit;
                exp_taken  <= in_valid && taken;
                exp_uop    <= in_uop;
                exp_rd     <= in_rd;
                exp_result <= alu_val;
                exp_tgt    <= in_pc + in_imm;
                if (in_valid && alu_hit && in_rd != '0) begin
                    shadow[in_rd] <= alu_val;
                end
            end
        end
    end

    task automatic flag_mismatch(string sig, logic [31:0] got, logic [31:0] want);
        err_count++;
        $error("CHECK FAILED t=%0t %s got %0h expected %0h", $time, sig, got, want);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) ex1_valid == exp_valid)
        else flag_mismatch("ex1_valid", 32'($sampled(ex1_valid)), 32'($sampled(exp_valid)));
    a_res_v: assert property (@(posedge clk) disable iff (!rst_n)
        ex1_result_valid == exp_res_v)
        else flag_mismatch("ex1_result_valid",
            32'($sampled(ex1_result_valid)), 32'($sampled(exp_res_v)));
    a_br_v: assert property (@(posedge clk) disable iff (!rst_n) ex1_br_valid == exp_br_v)
        else flag_mismatch("ex1_br_valid",
            32'($sampled(ex1_br_valid)), 32'($sampled(exp_br_v)));
    a_taken: assert property (@(posedge clk) disable iff (!rst_n) ex1_br_taken == exp_taken)
        else flag_mismatch("ex1_br_taken",
            32'($sampled(ex1_br_taken)), 32'($sampled(exp_taken)));
    a_uop: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> ex1_uop == exp_uop)
        else flag_mismatch("ex1_uop", 32'($sampled(ex1_uop)), 32'($sampled(exp_uop)));
    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> ex1_rd == exp_rd)
        else flag_mismatch("ex1_rd", 32'($sampled(ex1_rd)), 32'($sampled(exp_rd)));
    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        exp_res_v |-> ex1_result == exp_result)
        else flag_mismatch("ex1_result", $sampled(ex1_result), $sampled(exp_result));
    a_tgt: assert property (@(posedge clk) disable iff (!rst_n)
        exp_br_v |-> ex1_br_tgt == exp_tgt)
        else flag_mismatch("ex1_br_tgt", $sampled(ex1_br_tgt), $sampled(exp_tgt));

    // Every EX1 output holds across a stalled edge
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_q |-> out_now == out_prev)
        else begin
            err_count++;
            $error("CHECK FAILED t=%0t ex1 outputs under stall got %0h expected %0h",
                   $time, $sampled(out_now), $sampled(out_prev));
        end

endmodule

bind exe_core exe_core_asserts chk (.*);

// ==== bench/exe_core_tb.sv ====
`timescale 1ns/1ns

module exe_core_tb
    import rv_pkg::*;
();

    localparam int period_ns    = 4;
    localparam int reset_cycles = 10;
    localparam int n_random     = 2000;
    // Directed, idle and tail cycles fit inside the extra 100
    localparam int timeout_ns   = (reset_cycles + n_random + 100) * period_ns;

    logic     clk;
    logic     rst_n;
    logic     stall;
    logic     in_valid;
    t_uop     in_uop;
    t_reg_idx in_rs1;
    t_reg_idx in_rs2;
    t_reg_idx in_rd;
    t_optype  in_src2_type;
    t_data    in_imm;
    t_data    in_pc;
    logic     ex1_valid;
    t_uop     ex1_uop;
    t_reg_idx ex1_rd;
    t_data    ex1_result;
    logic     ex1_result_valid;
    logic     ex1_br_valid;
    logic     ex1_br_taken;
    t_data    ex1_br_tgt;

    exe_core UUT (.*);

    always #(period_ns / 2) clk = ~clk;

    // Directed micro-op, presented until the next edge
    task automatic issue(t_uop uop, t_reg_idx rs1, t_reg_idx rs2, t_reg_idx rd,
                         t_optype kind, t_data imm);
        @(posedge clk);
        #1;
        stall        = 1'b0;
        in_valid     = 1'b1;
        in_uop       = uop;
        in_rs1       = rs1;
        in_rs2       = rs2;
        in_rd        = rd;
        in_src2_type = kind;
        in_imm       = imm;
        in_pc        = in_pc + 32'd4;
    endtask

    task automatic idle(int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            stall    = 1'b0;
        end
    endtask

    task automatic random_uop();
        logic [31:0] r;
        logic [4:0]  mask;
        r            = $urandom;
        // Half the time only x0..x7, for dense dependencies and equal operands
        mask         = r[31] ? 5'd7 : 5'd31;
        in_valid     = (r[2:0] != 3'd0);
        in_uop       = t_uop'(r[7:4] % 4'd15);
        in_rs1       = r[12:8] & mask;
        in_rs2       = r[17:13] & mask;
        in_rd        = r[22:18] & mask;
        in_src2_type = t_optype'(r[24]);
        in_imm       = r[25] ? $urandom : {27'd0, r[30:26]};
        in_pc        = $urandom & 32'hffff_fffc;
    endtask

    initial begin
        void'($urandom(32'h10b97000));
        clk          = 1'b0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        in_valid     = 1'b0;
        in_uop       = U_INVALID;
        in_rs1       = '0;
        in_rs2       = '0;
        in_rd        = '0;
        in_src2_type = OP_REG;
        in_imm       = '0;
        in_pc        = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(3);

        // Dropped write to x0, then every register loaded from x0
        issue(U_ADD, 5'd0, 5'd0, 5'd0, OP_IMM, 32'h1234_5678);
        for (int i = 1; i < num_regs; i++) begin
            issue(U_ADD, 5'd0, 5'd0, t_reg_idx'(i), OP_IMM, t_data'(i) * 32'h9e37_79b9);
        end
        // Back-to-back chain, x3 ends at zero so the BEQ is taken
        issue(U_ADD, 5'd1, 5'd2, 5'd1, OP_REG, '0);
        issue(U_SUB, 5'd1, 5'd1, 5'd3, OP_REG, '0);
        issue(U_BEQ, 5'd3, 5'd0, 5'd0, OP_IMM, 32'h0000_0040);

        for (int n = 0; n < n_random; n++) begin
            @(posedge clk);
            #1;
            // Stalled micro-op stays on the inputs
            if (!stall) begin
                random_uop();
            end
            stall = ($urandom_range(7) == 0);
        end
        idle(3);

        if (UUT.chk.err_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "checker reported mismatches");
        end
    end

    // Mid-cycle, after the assertions of the rising edge have run
    always @(negedge clk) begin
        if (UUT.chk.err_count != 0) begin
            $display("Some tests failed");
            $fatal(1, "checker reported a mismatch");
        end
    end

    initial begin
        #(timeout_ns);
        $display("Some tests failed");
        $fatal(1, "watchdog expired before the stimulus finished");
    end

endmodule

// ==== filelist.f ====
src/rv_pkg.sv
src/reg_file.sv
src/ialu.sv
src/ibr.sv
src/exe.sv
src/exe_core.sv
bench/exe_core_asserts.sv
bench/exe_core_tb.sv

// ==== src/exe.sv ====
`timescale 1ns/1ns

module exe
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,

    input  logic     in_valid,
    input  t_uop     in_uop,
    input  t_reg_idx in_rd,
    input  t_optype  in_src2_type,
    input  t_data    in_imm,
    input  t_data    in_pc,
    input  t_data    rdata1,
    input  t_data    rdata2,

    output logic     wr_en,
    output t_reg_idx wr_idx,
    output t_data    wr_data,

    output logic     ex1_valid,
    output t_uop     ex1_uop,
    output t_reg_idx ex1_rd,
    output t_data    ex1_result,
    output logic     ex1_result_valid,
    output logic     ex1_br_valid,
    output logic     ex1_br_taken,
    output t_data    ex1_br_tgt
);

    logic  accept;
    t_data src2_ex0;

    logic  alu_valid_ex0;
    t_data alu_result_ex0;

    logic  br_valid_ex0;
    logic  br_taken_ex0;
    t_data br_tgt_ex0;

    t_data result_ex0;

    assign accept = in_valid && !stall;

    // Branches keep the immediate for the offset, so they compare registers
    assign src2_ex0 = (is_branch(in_uop) || in_src2_type == OP_REG) ? rdata2 : in_imm;

    ialu ialu_i (
        .uop          (in_uop),
        .src1         (rdata1),
        .src2         (src2_ex0),
        .result_valid (alu_valid_ex0),
        .result       (alu_result_ex0)
    );

    ibr ibr_i (
        .uop      (in_uop),
        .src1     (rdata1),
        .src2     (src2_ex0),
        .pc       (in_pc),
        .imm      (in_imm),
        .br_valid (br_valid_ex0),
        .taken    (br_taken_ex0),
        .target   (br_tgt_ex0)
    );

    // Result merge, only the ALU produces register data
    assign result_ex0 = alu_valid_ex0 ? alu_result_ex0 : '0;

    // Writeback lands on the same edge that loads EX1
    assign wr_en   = accept && alu_valid_ex0 && (in_rd != '0);
    assign wr_idx  = in_rd;
    assign wr_data = result_ex0;

    // EX1 register, holds while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex1_valid        <= 1'b0;
            ex1_uop          <= U_INVALID;
            ex1_rd           <= '0;
            ex1_result       <= '0;
            ex1_result_valid <= 1'b0;
            ex1_br_valid     <= 1'b0;
            ex1_br_taken     <= 1'b0;
            ex1_br_tgt       <= '0;
        end else if (!stall) begin
            ex1_valid        <= in_valid;
            ex1_uop          <= in_valid ? in_uop : U_INVALID;
            ex1_rd           <= in_rd;
            ex1_result       <= result_ex0;
            ex1_result_valid <= in_valid && alu_valid_ex0;
            ex1_br_valid     <= in_valid && br_valid_ex0;
            ex1_br_taken     <= in_valid && br_taken_ex0;
            ex1_br_tgt       <= br_tgt_ex0;
        end
    end

endmodule

// ==== src/exe_core.sv ====
`timescale 1ns/1ns

module exe_core
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,

    input  logic     in_valid,
    input  t_uop     in_uop,
    input  t_reg_idx in_rs1,
    input  t_reg_idx in_rs2,
    input  t_reg_idx in_rd,
    input  t_optype  in_src2_type,
    input  t_data    in_imm,
    input  t_data    in_pc,

    output logic     ex1_valid,
    output t_uop     ex1_uop,
    output t_reg_idx ex1_rd,
    output t_data    ex1_result,
    output logic     ex1_result_valid,
    output logic     ex1_br_valid,
    output logic     ex1_br_taken,
    output t_data    ex1_br_tgt
);

    t_data    rdata1;
    t_data    rdata2;
    logic     wr_en;
    t_reg_idx wr_idx;
    t_data    wr_data;

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (in_rs1),
        .rs2     (in_rs2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    // Writeback path closes back into the register file
    exe exe_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall            (stall),
        .in_valid         (in_valid),
        .in_uop           (in_uop),
        .in_rd            (in_rd),
        .in_src2_type     (in_src2_type),
        .in_imm           (in_imm),
        .in_pc            (in_pc),
        .rdata1           (rdata1),
        .rdata2           (rdata2),
        .wr_en            (wr_en),
        .wr_idx           (wr_idx),
        .wr_data          (wr_data),
        .ex1_valid        (ex1_valid),
        .ex1_uop          (ex1_uop),
        .ex1_rd           (ex1_rd),
        .ex1_result       (ex1_result),
        .ex1_result_valid (ex1_result_valid),
        .ex1_br_valid     (ex1_br_valid),
        .ex1_br_taken     (ex1_br_taken),
        .ex1_br_tgt       (ex1_br_tgt)
    );

endmodule

// ==== src/ialu.sv ====
`timescale 1ns/1ns

module ialu
    import rv_pkg::*;
(
    input  t_uop  uop,
    input  t_data src1,
    input  t_data src2,

    output logic  result_valid,
    output t_data result
);

    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // Shift amount comes from the low bits of the second operand
    assign shamt       = src2[shamt_w-1:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    assign result_valid = is_alu(uop);

    always_comb begin
        case (uop)
            U_ADD: begin
                result = src1 + src2;
            end
            U_SUB: begin
                result = src1 - src2;
            end
            U_AND: begin
                result = src1 & src2;
            end
            U_OR: begin
                result = src1 | src2;
            end
            U_XOR: begin
                result = src1 ^ src2;
            end
            U_SLT: begin
                result = t_data'(lt_signed);
            end
            U_SLTU: begin
                result = t_data'(lt_unsigned);
            end
            U_SLL: begin
                result = src1 << shamt;
            end
            U_SRL: begin
                result = src1 >> shamt;
            end
            U_SRA: begin
                // Arithmetic, sign bit fills from the left
                result = t_data'($signed(src1) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== src/ibr.sv ====
`timescale 1ns/1ns

module ibr
    import rv_pkg::*;
(
    input  t_uop  uop,
    input  t_data src1,
    input  t_data src2,
    input  t_data pc,
    input  t_data imm,

    output logic  br_valid,
    output logic  taken,
    output t_data target
);

    logic eq;
    logic lt;

    assign eq = (src1 == src2);
    assign lt = $signed(src1) < $signed(src2);

    assign br_valid = is_branch(uop);

    // Target is computed regardless of the outcome
    assign target = pc + imm;

    always_comb begin
        case (uop)
            U_BEQ: begin
                taken = eq;
            end
            U_BNE: begin
                taken = !eq;
            end
            U_BLT: begin
                taken = lt;
            end
            U_BGE: begin
                taken = !lt;
            end
            default: begin
                // Non-branch ops never report taken
                taken = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ns

module reg_file
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  t_reg_idx rs1,
    input  t_reg_idx rs2,
    output t_data    rdata1,
    output t_data    rdata2,

    input  logic     wr_en,
    input  t_reg_idx wr_idx,
    input  t_data    wr_data
);

    t_data regs [num_regs];
    logic  wr_ok;

    // x0 is never written
    assign wr_ok = wr_en && (wr_idx != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational reads, x0 forced to zero
    always_comb begin
        rdata1 = (rs1 == '0) ? '0 : regs[rs1];
        rdata2 = (rs2 == '0) ? '0 : regs[rs2];
    end

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen      = 32;
    localparam int num_regs  = 32;
    localparam int reg_idx_w = 5;
    localparam int shamt_w   = 5;

    typedef logic [xlen-1:0]      t_data;
    typedef logic [reg_idx_w-1:0] t_reg_idx;

    // Zero encoding is the invalid op, so a cleared EX1 register holds no work
    typedef enum logic [3:0] {
        U_INVALID = 4'd0,
        U_ADD     = 4'd1,
        U_SUB     = 4'd2,
        U_AND     = 4'd3,
        U_OR      = 4'd4,
        U_XOR     = 4'd5,
        U_SLT     = 4'd6,
        U_SLTU    = 4'd7,
        U_SLL     = 4'd8,
        U_SRL     = 4'd9,
        U_SRA     = 4'd10,
        U_BEQ     = 4'd11,
        U_BNE     = 4'd12,
        U_BLT     = 4'd13,
        U_BGE     = 4'd14
    } t_uop;

    // Kind of the second source operand
    typedef enum logic {
        OP_REG = 1'b0,
        OP_IMM = 1'b1
    } t_optype;

    // Conditional branch opcodes
    function automatic logic is_branch(t_uop uop);
        return uop inside {U_BEQ, U_BNE, U_BLT, U_BGE};
    endfunction

    // Opcodes handled by the integer ALU
    function automatic logic is_alu(t_uop uop);
        return uop inside {
            U_ADD, U_SUB, U_AND, U_OR, U_XOR,
            U_SLT, U_SLTU, U_SLL, U_SRL, U_SRA
        };
    endfunction

endpackage
